// File: exec_pkg.sv
// Shared types, encodings and constants for the RV32I execute stage
package exec_pkg;

    // Basic datapath widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    // Major opcodes handled by this stage
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_CSR_IMM
    } instr_format_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic {OP1_RS1, OP1_PC} alu_op1_src_e;
    typedef enum logic {OP2_RS2, OP2_IMM} alu_op2_src_e;

    // Values follow branch funct3 so the decoder can cast directly
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {RD_SRC_ALU, RD_SRC_PC4, RD_SRC_CSR} rd_src_e;

    // Low two bits of the CSR funct3
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // Marker for latched PC and instruction out of reset
    localparam word_t RESET_PC_WORD = 32'hDEADBEEF;
    localparam word_t INSTR_BYTES   = 32'd4;

endpackage

// File: exec_ctrl_if.sv
// Decoded control bundle passed from the decoder to the datapath blocks
`timescale 1ns/1ps

interface exec_ctrl_if (
    input logic clk,
    input logic rst_n
);
    exec_pkg::alu_op_e       alu_op;
    exec_pkg::alu_op1_src_e  alu_op1_src;
    exec_pkg::alu_op2_src_e  alu_op2_src;
    exec_pkg::cmp_op_e       cmp_op;
    logic                    cond_branch;
    logic                    uncond_branch;
    logic                    jalr;
    exec_pkg::rd_src_e       rd_src;
    logic                    rd_we;
    logic                    csr_en;
    exec_pkg::csr_op_e       csr_op;
    logic                    csr_use_uimm;
    exec_pkg::instr_format_e instr_format;

    // Decoder side, clock only for its checks
    modport ctrl (
        input  clk, rst_n,
        output alu_op, alu_op1_src, alu_op2_src, cmp_op, cond_branch, uncond_branch,
        jalr, rd_src, rd_we, csr_en, csr_op, csr_use_uimm, instr_format
    );

    modport dp (
        input alu_op, alu_op1_src, alu_op2_src, cmp_op, cond_branch, uncond_branch,
        jalr, rd_src, rd_we, csr_en, csr_op, csr_use_uimm, instr_format
    );

endinterface

// File: exec_control.sv
// Instruction decoder producing the control bundle and the illegal flag
`timescale 1ns/1ps

module exec_control (
    input  exec_pkg::word_t instr,
    input  logic            exec_valid,
    exec_ctrl_if.ctrl       ctrl,
    output logic            illegal_instr
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;
    logic       csr_raw;
    logic       cond_raw;
    logic       uncond_raw;
    logic       illegal;
    logic       ok;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // Defaults describe a harmless ADD with no side effects
        ctrl.alu_op       = exec_pkg::ALU_ADD;
        ctrl.alu_op1_src  = exec_pkg::OP1_RS1;
        ctrl.alu_op2_src  = exec_pkg::OP2_RS2;
        ctrl.cmp_op       = exec_pkg::cmp_op_e'(funct3);
        ctrl.jalr         = 1'b0;
        ctrl.rd_src       = exec_pkg::RD_SRC_ALU;
        ctrl.csr_op       = exec_pkg::csr_op_e'(funct3[1:0]);
        ctrl.csr_use_uimm = funct3[2];
        ctrl.instr_format = exec_pkg::FMT_R;
        writes_rd         = 1'b0;
        csr_raw           = 1'b0;
        cond_raw          = 1'b0;
        uncond_raw        = 1'b0;
        illegal           = 1'b0;
        case (instr[6:0])
            exec_pkg::OPCODE_OP, exec_pkg::OPCODE_OP_IMM: begin
                writes_rd = 1'b1;
                if (instr[5]) begin
                    // Register form, SUB and SRA only with funct7 bit 5
                    illegal = !(funct7 == 7'b0 ||
                               (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
                end else begin
                    ctrl.instr_format = exec_pkg::FMT_I;
                    ctrl.alu_op2_src  = exec_pkg::OP2_IMM;
                    // Shift immediates carry funct7 in the upper bits
                    if (funct3 == 3'b001)
                        illegal = funct7 != 7'b0;
                    else if (funct3 == 3'b101)
                        illegal = !(funct7 == 7'b0 || funct7 == 7'b0100000);
                end
                case (funct3)
                    3'b000:  ctrl.alu_op = (instr[5] && funct7[5]) ? exec_pkg::ALU_SUB
                                                                   : exec_pkg::ALU_ADD;
                    3'b001:  ctrl.alu_op = exec_pkg::ALU_SLL;
                    3'b010:  ctrl.alu_op = exec_pkg::ALU_SLT;
                    3'b011:  ctrl.alu_op = exec_pkg::ALU_SLTU;
                    3'b100:  ctrl.alu_op = exec_pkg::ALU_XOR;
                    3'b101:  ctrl.alu_op = funct7[5] ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
                    3'b110:  ctrl.alu_op = exec_pkg::ALU_OR;
                    default: ctrl.alu_op = exec_pkg::ALU_AND;
                endcase
            end
            exec_pkg::OPCODE_LUI, exec_pkg::OPCODE_AUIPC: begin
                // LUI adds to x0, the stage zeroes rs1 for U format
                ctrl.instr_format = exec_pkg::FMT_U;
                ctrl.alu_op2_src  = exec_pkg::OP2_IMM;
                ctrl.alu_op1_src  = instr[5] ? exec_pkg::OP1_RS1 : exec_pkg::OP1_PC;
                writes_rd         = 1'b1;
            end
            exec_pkg::OPCODE_JAL: begin
                ctrl.instr_format = exec_pkg::FMT_J;
                ctrl.rd_src       = exec_pkg::RD_SRC_PC4;
                writes_rd         = 1'b1;
                uncond_raw        = 1'b1;
            end
            exec_pkg::OPCODE_JALR: begin
                // ALU forms rs1 plus imm for the target
                ctrl.instr_format = exec_pkg::FMT_I;
                ctrl.alu_op2_src  = exec_pkg::OP2_IMM;
                ctrl.rd_src       = exec_pkg::RD_SRC_PC4;
                ctrl.jalr         = 1'b1;
                illegal           = funct3 != 3'b000;
                writes_rd         = 1'b1;
                uncond_raw        = 1'b1;
            end
            exec_pkg::OPCODE_BRANCH: begin
                ctrl.instr_format = exec_pkg::FMT_B;
                illegal           = funct3[2:1] == 2'b01;
                cond_raw          = 1'b1;
            end
            exec_pkg::OPCODE_SYSTEM: begin
                // ECALL, EBREAK and funct3 100 not handled here
                ctrl.instr_format = funct3[2] ? exec_pkg::FMT_CSR_IMM : exec_pkg::FMT_I;
                ctrl.rd_src       = exec_pkg::RD_SRC_CSR;
                illegal           = funct3[1:0] == 2'b00;
                writes_rd         = 1'b1;
                csr_raw           = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // Only a valid, legal instruction may have side effects
    assign ok                 = exec_valid && !illegal;
    assign ctrl.rd_we         = ok && writes_rd && (instr[11:7] != 5'd0);
    assign ctrl.csr_en        = ok && csr_raw;
    assign ctrl.cond_branch   = ok && cond_raw;
    assign ctrl.uncond_branch = ok && uncond_raw;
    assign illegal_instr      = exec_valid && illegal;

    // Nothing leaves the decoder in an idle cycle
    a_idle_quiet: assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst_n)
        !exec_valid |-> !(ctrl.rd_we || ctrl.csr_en || illegal_instr));

endmodule

// File: exec_imm_gen.sv
// Immediate generator for every RV32I format plus the CSR uimm
`timescale 1ns/1ps

module exec_imm_gen (
    input  exec_pkg::word_t         instr,
    input  exec_pkg::instr_format_e instr_format,
    output exec_pkg::word_t         imm
);

    logic sign;

    // Sign always sits in bit 31
    assign sign = instr[31];

    always_comb begin
        case (instr_format)
            exec_pkg::FMT_I:
                imm = {{20{sign}}, instr[31:20]};
            exec_pkg::FMT_S:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are even, bit 0 implied
            exec_pkg::FMT_B:
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            exec_pkg::FMT_U:
                imm = {instr[31:12], 12'b0};
            exec_pkg::FMT_J:
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            // rs1 field as a zero-extended 5-bit value
            exec_pkg::FMT_CSR_IMM:
                imm = {27'b0, instr[19:15]};
            // R format has no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

// File: exec_reg_file.sv
// Integer register file, two combinational reads and one clocked write
`timescale 1ns/1ps

module exec_reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  exec_pkg::reg_idx_t rs1_idx,
    input  exec_pkg::reg_idx_t rs2_idx,
    output exec_pkg::word_t   rs1_data,
    output exec_pkg::word_t   rs2_data,
    input  exec_pkg::reg_idx_t rd_idx,
    input  exec_pkg::word_t   rd_wdata,
    input  logic              rd_we
);

    // No storage behind x0
    exec_pkg::word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != 5'd0) begin
            regs[rd_idx] <= rd_wdata;
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

    // Decoder already drops writes to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rd_we |-> rd_idx != 5'd0);

endmodule

// File: exec_alu.sv
// Operand selection and the ten-operation integer ALU
`timescale 1ns/1ps

module exec_alu (
    exec_ctrl_if.dp         ctrl,
    input  exec_pkg::word_t rs1_data,
    input  exec_pkg::word_t rs2_data,
    input  exec_pkg::word_t pc,
    input  exec_pkg::word_t imm,
    output exec_pkg::word_t alu_result
);

    exec_pkg::word_t op1;
    exec_pkg::word_t op2;
    logic [4:0]      shamt;

    // Source muxes
    assign op1 = (ctrl.alu_op1_src == exec_pkg::OP1_PC) ? pc : rs1_data;
    assign op2 = (ctrl.alu_op2_src == exec_pkg::OP2_IMM) ? imm : rs2_data;

    // Shifts use the low five bits only
    assign shamt = op2[4:0];

    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::ALU_ADD:  alu_result = op1 + op2;
            exec_pkg::ALU_SUB:  alu_result = op1 - op2;
            exec_pkg::ALU_SLL:  alu_result = op1 << shamt;
            exec_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
            exec_pkg::ALU_SLTU: alu_result = {31'b0, op1 < op2};
            exec_pkg::ALU_XOR:  alu_result = op1 ^ op2;
            exec_pkg::ALU_SRL:  alu_result = op1 >> shamt;
            // Arithmetic shift fills with the sign
            exec_pkg::ALU_SRA:  alu_result = $signed(op1) >>> shamt;
            exec_pkg::ALU_OR:   alu_result = op1 | op2;
            exec_pkg::ALU_AND:  alu_result = op1 & op2;
            default:            alu_result = '0;
        endcase
    end

endmodule

// File: exec_branch_cmp.sv
// Branch condition evaluation, target address and redirect decision
`timescale 1ns/1ps

module exec_branch_cmp (
    exec_ctrl_if.dp         ctrl,
    input  exec_pkg::word_t rs1_data,
    input  exec_pkg::word_t rs2_data,
    input  exec_pkg::word_t pc,
    input  exec_pkg::word_t imm,
    input  exec_pkg::word_t alu_result,
    output logic            branch_en,
    output exec_pkg::word_t branch_target
);

    logic taken;

    always_comb begin
        case (ctrl.cmp_op)
            exec_pkg::CMP_EQ:  taken = rs1_data == rs2_data;
            exec_pkg::CMP_NE:  taken = rs1_data != rs2_data;
            exec_pkg::CMP_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
            exec_pkg::CMP_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            exec_pkg::CMP_LTU: taken = rs1_data < rs2_data;
            exec_pkg::CMP_GEU: taken = rs1_data >= rs2_data;
            default:           taken = 1'b0;
        endcase
    end

    // Jumps always redirect
    assign branch_en = ctrl.uncond_branch || (ctrl.cond_branch && taken);

    // JALR target is rs1 plus imm with bit 0 cleared
    assign branch_target = ctrl.jalr ? {alu_result[31:1], 1'b0} : pc + imm;

endmodule

// File: exec_stage.sv
// Execute stage top with input latch, writeback select and CSR port
`timescale 1ns/1ps

module exec_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  exec_pkg::word_t     instr,
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     csr_rdata,
    output logic                branch_en,
    output exec_pkg::word_t     branch_target,
    output logic                csr_we,
    output exec_pkg::word_t     csr_wdata,
    output exec_pkg::csr_addr_t csr_sel,
    output logic                rd_we,
    output exec_pkg::reg_idx_t  rd_idx,
    output exec_pkg::word_t     rd_wdata,
    output logic                illegal_instr
);

    exec_pkg::word_t    instr_q;
    exec_pkg::word_t    pc_q;
    logic               exec_valid;
    exec_pkg::word_t    imm;
    exec_pkg::word_t    rs1_data;
    exec_pkg::word_t    rs2_data;
    exec_pkg::word_t    alu_result;
    exec_pkg::word_t    csr_src;
    exec_pkg::reg_idx_t rs1_idx;
    logic               csr_src_zero;

    exec_ctrl_if ctrl_bus (.clk(clk), .rst_n(rst_n));

    // Input latch, loaded on every strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q    <= exec_pkg::RESET_PC_WORD;
            pc_q       <= exec_pkg::RESET_PC_WORD;
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= instr_valid;
            if (instr_valid) begin
                instr_q <= instr;
                pc_q    <= pc;
            end
        end
    end

    // U format has no rs1 field, read x0 so LUI adds zero
    assign rs1_idx = (ctrl_bus.instr_format == exec_pkg::FMT_U) ? 5'd0 : instr_q[19:15];
    assign rd_idx  = instr_q[11:7];
    assign rd_we   = ctrl_bus.rd_we;

    exec_control    u_control (.instr(instr_q), .exec_valid(exec_valid), .ctrl(ctrl_bus),
                               .illegal_instr(illegal_instr));
    exec_imm_gen    u_imm_gen (.instr(instr_q), .instr_format(ctrl_bus.instr_format), .imm(imm));
    exec_reg_file   u_reg_file (.clk(clk), .rst_n(rst_n), .rs1_idx(rs1_idx),
                                .rs2_idx(instr_q[24:20]), .rs1_data(rs1_data),
                                .rs2_data(rs2_data), .rd_idx(rd_idx), .rd_wdata(rd_wdata),
                                .rd_we(ctrl_bus.rd_we));
    exec_alu        u_alu (.ctrl(ctrl_bus), .rs1_data(rs1_data), .rs2_data(rs2_data),
                           .pc(pc_q), .imm(imm), .alu_result(alu_result));
    exec_branch_cmp u_branch_cmp (.ctrl(ctrl_bus), .rs1_data(rs1_data), .rs2_data(rs2_data),
                                  .pc(pc_q), .imm(imm), .alu_result(alu_result),
                                  .branch_en(branch_en), .branch_target(branch_target));

    // Writeback select
    always_comb begin
        case (ctrl_bus.rd_src)
            exec_pkg::RD_SRC_PC4: rd_wdata = pc_q + exec_pkg::INSTR_BYTES;
            exec_pkg::RD_SRC_CSR: rd_wdata = csr_rdata;
            default:              rd_wdata = alu_result;
        endcase
    end

    // CSR port, imm already holds the zero-extended uimm
    assign csr_sel      = instr_q[31:20];
    assign csr_src      = ctrl_bus.csr_use_uimm ? imm : rs1_data;
    assign csr_src_zero = instr_q[19:15] == 5'd0;
    // Set and clear with a zero source only read
    assign csr_we       = ctrl_bus.csr_en &&
                          !(ctrl_bus.csr_op != exec_pkg::CSR_WRITE && csr_src_zero);

    always_comb begin
        case (ctrl_bus.csr_op)
            exec_pkg::CSR_SET:   csr_wdata = csr_rdata | csr_src;
            exec_pkg::CSR_CLEAR: csr_wdata = csr_rdata & ~csr_src;
            default:             csr_wdata = csr_src;
        endcase
    end

    // A CSR write only follows a strobe one edge earlier
    a_csr_we_strobed: assert property (@(posedge clk) disable iff (!rst_n)
        csr_we |-> $past(instr_valid));

endmodule

// File: tb_exec_stage.sv
// Directed testbench for the RV32I execute stage with shadow register file and CSR model
`timescale 1ns/1ps

module tb_exec_stage;

    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] SYSTEM = 7'b1110011;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] csr_rdata;
    logic        branch_en;
    logic [31:0] branch_target;
    logic        csr_we;
    logic [31:0] csr_wdata;
    logic [11:0] csr_sel;
    logic        rd_we;
    logic [4:0]  rd_idx;
    logic [31:0] rd_wdata;
    logic        illegal_instr;

    logic [31:0] shadow [0:31];
    logic [31:0] csr_mem [0:15];
    logic [31:0] cur_pc;
    int          errors;
    int          checks;
    int          k;

    exec_stage dut0 (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .csr_rdata(csr_rdata), .branch_en(branch_en), .branch_target(branch_target),
        .csr_we(csr_we), .csr_wdata(csr_wdata), .csr_sel(csr_sel), .rd_we(rd_we),
        .rd_idx(rd_idx), .rd_wdata(rd_wdata), .illegal_instr(illegal_instr)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // CSR file answers in the same cycle and writes on the edge
    assign csr_rdata = csr_mem[csr_sel[3:0]];
    always @(posedge clk) begin
        if (csr_we)
            csr_mem[csr_sel[3:0]] <= csr_wdata;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Branch offset scrambled into the B layout
    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I integer op by funct3 where alt picks SUB or SRA
    function automatic logic [31:0] ref_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Waits for the next rising edge and steps 2 ns past it
    task automatic next_cycle();
        int hi_wait;
        int lo_wait;
        hi_wait = 0;
        lo_wait = 0;
        // Polls sit a quarter step off the clock edges
        #0.25;
        while (clk === 1'b1 && hi_wait < 40) begin
            #0.5;
            hi_wait++;
        end
        while (clk === 1'b0 && lo_wait < 40) begin
            #0.5;
            lo_wait++;
        end
        if (hi_wait >= 40 || lo_wait >= 40) begin
            $display("Timeout: no rising clock edge seen within 20 ns");
            $display("Test FAILED");
            $finish;
        end else begin
            #1.75;
        end
    endtask

    // One strobe that returns inside the result cycle
    task automatic issue(input logic [31:0] word);
        instr_valid = 1'b1;
        instr       = word;
        pc          = cur_pc;
        next_cycle();
        instr_valid = 1'b0;
        cur_pc      = cur_pc + 32'd4;
    endtask

    task automatic compare(input string test, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
        end
    endtask

    task automatic expect_quiet(input string test);
        compare(test, "branch_en", 32'd0, branch_en);
        compare(test, "csr_we", 32'd0, csr_we);
        compare(test, "rd_we", 32'd0, rd_we);
        compare(test, "illegal_instr", 32'd0, illegal_instr);
    endtask

    // Issues a register-writing instruction and tracks it in the shadow file
    task automatic run_and_check_rd(input string test, input logic [31:0] word,
                                    input logic [4:0] rd, input logic [31:0] exp);
        issue(word);
        compare(test, "rd_we", (rd != 5'd0) ? 32'd1 : 32'd0, rd_we);
        compare(test, "rd_idx", rd, rd_idx);
        if (rd != 5'd0) begin
            compare(test, "rd_wdata", exp, rd_wdata);
            shadow[rd] = exp;
        end
    endtask

    // LUI plus ADDI with the upper part rounded for the signed low part
    task automatic load_reg(input string test, input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) & 32'hFFFF_F000;
        run_and_check_rd(test, {upper[31:12], rd, LUI}, rd, upper);
        run_and_check_rd(test, i_type(v[11:0], rd, 3'd0, rd, OP_IMM), rd, v);
    endtask

    task automatic idle_outputs();
        run_and_check_rd("idle", i_type(12'h001, 5'd0, 3'd0, 5'd3, OP_IMM), 5'd3, 32'd1);
        next_cycle();
        expect_quiet("idle");
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        int          i;
        // Positive versus negative separates SLT from SLTU
        a = $urandom() & 32'h7FFF_FFFF;
        b = $urandom() | 32'h8000_0000;
        load_reg("alu_load", 5'd1, a);
        load_reg("alu_load", 5'd2, b);
        for (i = 0; i < 8; i++) begin
            f3 = i[2:0];
            run_and_check_rd("alu_r", r_type(7'd0, 5'd1, 5'd2, f3, 5'd8 + i[4:0], OP),
                             5'd8 + i[4:0], ref_op(f3, 1'b0, b, a));
        end
        // Reads x15 written by the previous strobe
        run_and_check_rd("alu_chain", r_type(7'd0, 5'd8, 5'd15, 3'd0, 5'd5, OP), 5'd5,
                         shadow[15] + shadow[8]);
        run_and_check_rd("alu_sub", r_type(7'b0100000, 5'd1, 5'd2, 3'd0, 5'd24, OP), 5'd24,
                         ref_op(3'd0, 1'b1, b, a));
        run_and_check_rd("alu_sra", r_type(7'b0100000, 5'd1, 5'd2, 3'd5, 5'd25, OP), 5'd25,
                         ref_op(3'd5, 1'b1, b, a));
        // Index 8 is SRAI on the negative operand
        for (i = 0; i < 9; i++) begin
            f3  = (i == 8) ? 3'd5 : i[2:0];
            imm = $urandom();
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {1'b0, i == 8, 5'd0, imm[4:0]};
            run_and_check_rd("alu_i", i_type(imm, 5'd2, f3, 5'd16 + i[4:0], OP_IMM),
                             5'd16 + i[4:0], ref_op(f3, i == 8, shadow[2], sext12(imm)));
        end
    endtask

    task automatic jumps_and_upper();
        logic [31:0] u;
        logic [31:0] p;
        logic [20:0] joff;
        logic [11:0] imm;
        u = $urandom();
        run_and_check_rd("lui", {u[19:0], 5'd6, LUI}, 5'd6, {u[19:0], 12'd0});
        p = cur_pc;
        run_and_check_rd("auipc", {u[31:12], 5'd7, AUIPC}, 5'd7, p + {u[31:12], 12'd0});
        joff    = $urandom();
        joff[0] = 1'b0;
        p       = cur_pc;
        run_and_check_rd("jal", j_type(joff, 5'd9), 5'd9, p + 32'd4);
        compare("jal", "branch_en", 32'd1, branch_en);
        compare("jal", "branch_target", p + {{11{joff[20]}}, joff}, branch_target);
        // Force an odd sum so bit 0 must be cleared
        imm = $urandom();
        if (((shadow[1] + sext12(imm)) & 32'd1) == 32'd0)
            imm[0] = ~imm[0];
        p = cur_pc;
        run_and_check_rd("jalr", i_type(imm, 5'd1, 3'd0, 5'd10, JALR), 5'd10, p + 32'd4);
        compare("jalr", "branch_en", 32'd1, branch_en);
        compare("jalr", "branch_target", (shadow[1] + sext12(imm)) & ~32'd1, branch_target);
    endtask

    task automatic branch_conditions();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [12:0] boff;
        logic        taken;
        int          i;
        int          j;
        // Most negative value against one in both orders and then equal operands
        load_reg("branch_load", 5'd25, 32'h8000_0000);
        load_reg("branch_load", 5'd26, 32'd1);
        for (i = 0; i < 3; i++) begin
            rs1 = (i == 0) ? 5'd25 : 5'd26;
            rs2 = (i == 1) ? 5'd25 : 5'd26;
            a   = shadow[rs1];
            b   = shadow[rs2];
            for (j = 0; j < 8; j++) begin
                if (j != 2 && j != 3) begin
                    case (j)
                        0:       taken = a == b;
                        1:       taken = a != b;
                        4:       taken = $signed(a) < $signed(b);
                        5:       taken = $signed(a) >= $signed(b);
                        6:       taken = a < b;
                        default: taken = a >= b;
                    endcase
                    boff    = $urandom();
                    boff[0] = 1'b0;
                    p       = cur_pc;
                    issue(b_type(boff, rs2, rs1, j[2:0]));
                    compare("branch", "branch_en", taken, branch_en);
                    compare("branch", "rd_we", 32'd0, rd_we);
                    if (taken)
                        compare("branch", "branch_target", p + {{19{boff[12]}}, boff},
                                branch_target);
                end
            end
        end
    endtask

    task automatic csr_access();
        logic [11:0] addr;
        logic [4:0]  uimm;
        logic [31:0] old;
        logic [31:0] src;
        logic [31:0] exp;
        int          j;
        for (j = 1; j < 8; j++) begin
            if (j != 4) begin
                uimm = $urandom() | 32'd1;
                addr = 12'h340 + j[11:0];
                old  = csr_mem[addr[3:0]];
                src  = j[2] ? {27'd0, uimm} : shadow[1];
                case (j[1:0])
                    2'b01:   exp = src;
                    2'b10:   exp = old | src;
                    default: exp = old & ~src;
                endcase
                run_and_check_rd("csr", {addr, j[2] ? uimm : 5'd1, j[2:0], 5'd28, SYSTEM},
                                 5'd28, old);
                compare("csr", "csr_sel", addr, csr_sel);
                compare("csr", "csr_we", 32'd1, csr_we);
                compare("csr", "csr_wdata", exp, csr_wdata);
            end
        end
        // Set and clear with a zero source only read
        old = csr_mem[4'hA];
        run_and_check_rd("csr_rs_x0", {12'h34A, 5'd0, 3'b010, 5'd29, SYSTEM}, 5'd29, old);
        compare("csr_rs_x0", "csr_we", 32'd0, csr_we);
        old = csr_mem[4'hB];
        run_and_check_rd("csr_rci_0", {12'h34B, 5'd0, 3'b111, 5'd29, SYSTEM}, 5'd29, old);
        compare("csr_rci_0", "csr_we", 32'd0, csr_we);
    endtask

    task automatic illegal_and_x0();
        // LOAD opcode and an M-extension multiply that both target x5
        issue(i_type(12'h000, 5'd1, 3'b010, 5'd5, 7'b0000011));
        compare("illegal_load", "illegal_instr", 32'd1, illegal_instr);
        compare("illegal_load", "rd_we", 32'd0, rd_we);
        compare("illegal_load", "csr_we", 32'd0, csr_we);
        compare("illegal_load", "branch_en", 32'd0, branch_en);
        issue(r_type(7'b0000001, 5'd2, 5'd1, 3'd0, 5'd5, OP));
        compare("illegal_mul", "illegal_instr", 32'd1, illegal_instr);
        compare("illegal_mul", "rd_we", 32'd0, rd_we);
        run_and_check_rd("x0_write", i_type(12'h055, 5'd1, 3'd0, 5'd0, OP_IMM), 5'd0, 32'd0);
        compare("x0_write", "illegal_instr", 32'd0, illegal_instr);
        run_and_check_rd("x0_read", r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd30, OP), 5'd30, 32'd0);
        // x5 still holds its value from before the illegal strobes
        run_and_check_rd("illegal_kept", r_type(7'd0, 5'd0, 5'd5, 3'd0, 5'd31, OP), 5'd31,
                         shadow[5]);
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        cur_pc      = 32'h0000_1000;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        void'($urandom(32'h4aca06d2));
        for (k = 0; k < 32; k++)
            shadow[k] = 32'd0;
        for (k = 0; k < 16; k++)
            csr_mem[k] = 32'h5A00_0000 | (k * 32'h0011_0301);
        repeat (10) next_cycle();
        rst_n = 1'b1;
        expect_quiet("reset");
        idle_outputs();
        alu_ops();
        jumps_and_upper();
        branch_conditions();
        csr_access();
        illegal_and_x0();
        next_cycle();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: compile.f
exec_pkg.sv
exec_ctrl_if.sv
exec_control.sv
exec_imm_gen.sv
exec_reg_file.sv
exec_alu.sv
exec_branch_cmp.sv
exec_stage.sv
tb_exec_stage.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - exec_ctrl_if.sv
  - exec_control.sv
  - exec_imm_gen.sv
  - exec_reg_file.sv
  - exec_alu.sv
  - exec_branch_cmp.sv
  - exec_stage.sv
  - target: test
    files:
      - tb_exec_stage.sv
